/* rv32m_alu.f */
hdl/rv32i_types_pkg.sv
hdl/muldiv_pkg.sv
hdl/div_ctrl_if.sv
hdl/array_multiplier.sv
hdl/divider.sv
hdl/divider_control.sv
hdl/alu.sv
test/tb_clock_gen.sv
test/tb_alu.sv

/* test/tb_alu.sv */
module tb_alu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_fixed    = 26;
    localparam int n_random   = 32;
    localparam int n_tests    = n_fixed + n_random;
    localparam int clk_period = 8;
    localparam rv32i_types_pkg::funct7_t f7_base = 7'h00;
    localparam rv32i_types_pkg::funct7_t f7_m    = rv32i_types_pkg::funct7_muldiv;

    typedef struct packed {
        rv32i_types_pkg::alu_ops  op;
        rv32i_types_pkg::funct7_t f7;
        muldiv_pkg::word_t        a;
        muldiv_pkg::word_t        b;
        muldiv_pkg::word_t        exp;
    } vector_t;

    logic                     clk;
    logic                     rst_n;
    rv32i_types_pkg::alu_ops  aluop;
    rv32i_types_pkg::funct7_t funct7;
    muldiv_pkg::word_t        a;
    muldiv_pkg::word_t        b;
    logic                     start;
    logic                     busy;
    logic                     done;
    muldiv_pkg::word_t        f;

    vector_t     vectors [n_tests];
    int          n_filled = 0;
    int          n_errors = 0;
    int          n_passed = 0;
    int          n_failed = 0;
    logic [31:0] rng_state = 32'd43;  // LCG seed

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    alu i_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .aluop  (aluop),
        .funct7 (funct7),
        .a      (a),
        .b      (b),
        .start  (start),
        .busy   (busy),
        .done   (done),
        .f      (f)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected result straight from the RV32IM rules
    function automatic logic [31:0] ref_result(rv32i_types_pkg::alu_ops op,
                                               rv32i_types_pkg::funct7_t f7,
                                               logic [31:0] x, logic [31:0] y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic [63:0]        ux;
        logic [63:0]        uy;
        logic [63:0]        t;
        logic               zero_div;
        logic               ovf;
        sx = {{32{x[31]}}, x};
        sy = {{32{y[31]}}, y};
        ux = {32'h0, x};
        uy = {32'h0, y};
        zero_div = (y == 32'h0);
        ovf = (x == 32'h80000000) && (y == 32'hffffffff);
        sq = 64'sd0;
        sr = 64'sd0;
        if (!zero_div) begin
            sq = sx / sy;  // Truncates toward zero
            sr = sx % sy;  // Sign of the dividend
        end
        if (f7 != f7_m) begin
            case (op)
                rv32i_types_pkg::alu_add: t = ux + uy;
                rv32i_types_pkg::alu_sll: t = ux << y[4:0];
                rv32i_types_pkg::alu_sra: t = sx >> y[4:0];  // Sign bits come from the extension
                rv32i_types_pkg::alu_sub: t = ux - uy;
                rv32i_types_pkg::alu_xor: t = ux ^ uy;
                rv32i_types_pkg::alu_srl: t = ux >> y[4:0];
                rv32i_types_pkg::alu_or:  t = ux | uy;
                default:                  t = ux & uy;
            endcase
            return t[31:0];
        end
        case (op)
            rv32i_types_pkg::alu_add: t = sx * sy;
            rv32i_types_pkg::alu_sll: t = (sx * sy) >> 32;
            rv32i_types_pkg::alu_sra: t = (sx * uy) >> 32;  // MULHSU
            rv32i_types_pkg::alu_sub: t = (ux * uy) >> 32;
            rv32i_types_pkg::alu_xor: t = zero_div ? '1 : (ovf ? ux : sq);
            rv32i_types_pkg::alu_srl: t = zero_div ? '1 : ux / uy;
            rv32i_types_pkg::alu_or:  t = zero_div ? ux : (ovf ? 64'h0 : sr);
            default:                  t = zero_div ? ux : ux % uy;
        endcase
        return t[31:0];
    endfunction

    function automatic int expected_latency(rv32i_types_pkg::alu_ops op,
                                            rv32i_types_pkg::funct7_t f7);
        if (f7 != f7_m) begin
            return 1;
        end
        case (op)
            rv32i_types_pkg::alu_add, rv32i_types_pkg::alu_sll,
            rv32i_types_pkg::alu_sra, rv32i_types_pkg::alu_sub: return 2;
            default: return 35;  // Load, 32 steps, fixup, result register
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_entry(input rv32i_types_pkg::alu_ops op,
                             input rv32i_types_pkg::funct7_t f7,
                             input logic [31:0] x, input logic [31:0] y,
                             input logic [31:0] exp);
        vectors[n_filled].op  = op;
        vectors[n_filled].f7  = f7;
        vectors[n_filled].a   = x;
        vectors[n_filled].b   = y;
        vectors[n_filled].exp = exp;
        n_filled++;
    endtask

    task automatic fill_table();
        logic [31:0]              r;
        logic [31:0]              x;
        logic [31:0]              y;
        rv32i_types_pkg::alu_ops  op;
        rv32i_types_pkg::funct7_t f7;
        add_entry(rv32i_types_pkg::alu_add, f7_base, 32'h7fffffff, 32'h00000001, 32'h80000000);
        add_entry(rv32i_types_pkg::alu_sub, f7_base, 32'h00000000, 32'h00000001, 32'hffffffff);
        add_entry(rv32i_types_pkg::alu_sll, f7_base, 32'h00000001, 32'h00000024, 32'h00000010);
        add_entry(rv32i_types_pkg::alu_srl, f7_base, 32'h80000000, 32'h00000021, 32'h40000000);
        add_entry(rv32i_types_pkg::alu_sra, f7_base, 32'h80000000, 32'h0000001f, 32'hffffffff);
        add_entry(rv32i_types_pkg::alu_xor, f7_base, 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0);
        add_entry(rv32i_types_pkg::alu_or,  f7_base, 32'hf0f0f0f0, 32'h0f0f0000, 32'hfffff0f0);
        add_entry(rv32i_types_pkg::alu_and, f7_base, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
        add_entry(rv32i_types_pkg::alu_add, f7_m, 32'h80000000, 32'h80000000, 32'h00000000);
        add_entry(rv32i_types_pkg::alu_sll, f7_m, 32'h80000000, 32'h80000000, 32'h40000000);
        add_entry(rv32i_types_pkg::alu_sra, f7_m, 32'hffffffff, 32'hffffffff, 32'hffffffff);
        add_entry(rv32i_types_pkg::alu_sub, f7_m, 32'hffffffff, 32'hffffffff, 32'hfffffffe);
        add_entry(rv32i_types_pkg::alu_sll, f7_m, 32'hffffffff, 32'h00000002, 32'hffffffff);
        add_entry(rv32i_types_pkg::alu_add, f7_m, 32'hfffffffd, 32'h00000007, 32'hffffffeb);
        add_entry(rv32i_types_pkg::alu_xor, f7_m, 32'h00001234, 32'h00000000, 32'hffffffff);
        add_entry(rv32i_types_pkg::alu_srl, f7_m, 32'hdeadbeef, 32'h00000000, 32'hffffffff);
        add_entry(rv32i_types_pkg::alu_or,  f7_m, 32'hfffffff9, 32'h00000000, 32'hfffffff9);
        add_entry(rv32i_types_pkg::alu_and, f7_m, 32'hdeadbeef, 32'h00000000, 32'hdeadbeef);
        add_entry(rv32i_types_pkg::alu_xor, f7_m, 32'h80000000, 32'hffffffff, 32'h80000000);
        add_entry(rv32i_types_pkg::alu_or,  f7_m, 32'h80000000, 32'hffffffff, 32'h00000000);
        add_entry(rv32i_types_pkg::alu_xor, f7_m, 32'hfffffff9, 32'h00000002, 32'hfffffffd);
        add_entry(rv32i_types_pkg::alu_or,  f7_m, 32'hfffffff9, 32'h00000002, 32'hffffffff);
        add_entry(rv32i_types_pkg::alu_srl, f7_m, 32'hfffffff9, 32'h00000002, 32'h7ffffffc);
        add_entry(rv32i_types_pkg::alu_and, f7_m, 32'hfffffff9, 32'h00000002, 32'h00000001);
        add_entry(rv32i_types_pkg::alu_xor, f7_m, 32'h00000007, 32'hfffffffe, 32'hfffffffd);
        add_entry(rv32i_types_pkg::alu_or,  f7_m, 32'h00000007, 32'hfffffffe, 32'h00000001);
        while (n_filled < n_tests) begin
            r  = next_rand();
            op = rv32i_types_pkg::alu_ops'(r[30:28]);  // Upper LCG bits are the better ones
            f7 = r[31] ? f7_m : f7_base;
            x  = next_rand();
            y  = next_rand();
            if (r[25:24] == 2'b00) begin
                y = y >> 20;  // Small divisors and shift amounts
            end
            add_entry(op, f7, x, y, ref_result(op, f7, x, y));
        end
    endtask

    task automatic run_test(input int idx);
        vector_t     v;
        int          cycles;
        int          errors_before;
        logic [31:0] held;
        v = vectors[idx];
        errors_before = n_errors;
        held = f;
        @(posedge clk);
        #1;
        check_value("f hold", held, f);
        check_value("done", 32'h0, done);
        aluop  = v.op;
        funct7 = v.f7;
        a      = v.a;
        b      = v.b;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        a     = ~v.a;  // Operands are captured at start only
        b     = ~v.b;
        cycles = 1;
        while (done !== 1'b1) begin
            check_value("busy", 32'h1, busy);
            check_value("f hold", held, f);
            @(posedge clk);
            #1;
            cycles++;
        end
        check_value("busy", 32'h0, busy);
        check_value("f", v.exp, f);
        check_value("latency", expected_latency(v.op, v.f7), cycles);
        if (n_errors == errors_before) begin
            n_passed++;
        end else begin
            n_failed++;
        end
        $display("test %2d  op %0d  funct7 %h  a %h  b %h  f %h  %s", idx, v.op, v.f7,
                 v.a, v.b, f, (n_errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        aluop  = rv32i_types_pkg::alu_add;
        funct7 = f7_base;
        a      = '0;
        b      = '0;
        start  = 1'b0;
        fill_table();
        @(posedge rst_n);
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("done after reset", 32'h0, done);
            check_value("busy after reset", 32'h0, busy);
        end
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 n_tests, n_passed, n_failed, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Allows 40 cycles per table entry plus reset
    initial begin
        #((n_tests * 40 + 16) * clk_period);
        $display("Timeout: done never arrived before the time limit ran out");
        $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_alu

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;  // Release just after the second edge
    end

endmodule : tb_clock_gen

/* hdl/alu.sv */
module alu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv32i_types_pkg::alu_ops  aluop,
    input  rv32i_types_pkg::funct7_t funct7,
    input  muldiv_pkg::word_t        a,
    input  muldiv_pkg::word_t        b,
    input  logic                     start,
    output logic                     busy,
    output logic                     done,
    output muldiv_pkg::word_t        f
);

    logic mul_op;     // Live class decode
    logic div_op;
    logic base_op;
    logic a_signed;   // Operand signedness for M operations
    logic b_signed;

    logic signed [muldiv_pkg::xlen:0] a_ext;  // Conditioned multiplier operands
    logic signed [muldiv_pkg::xlen:0] b_ext;

    logic [$clog2(muldiv_pkg::xlen)-1:0] shamt;

    muldiv_pkg::word_t    base_res;
    muldiv_pkg::word_t    mul_res;
    muldiv_pkg::word_t    div_res;
    muldiv_pkg::product_t ans;
    muldiv_pkg::word_t    q;
    muldiv_pkg::word_t    r;

    rv32i_types_pkg::alu_ops op_q;  // Operation held for result selection
    logic mul_pending;              // Product lands this cycle
    logic div_done;

    div_ctrl_if div_bus ();

    // Decode class and signedness from the operation presented with start
    always_comb begin
        mul_op   = 1'b0;
        div_op   = 1'b0;
        a_signed = 1'b0;
        b_signed = 1'b0;
        if (funct7 == rv32i_types_pkg::funct7_muldiv) begin
            case (aluop)
                rv32i_types_pkg::alu_add, rv32i_types_pkg::alu_sll: begin
                    mul_op   = 1'b1;  // MUL, MULH
                    a_signed = 1'b1;
                    b_signed = 1'b1;
                end
                rv32i_types_pkg::alu_sra: begin
                    mul_op   = 1'b1;  // MULHSU
                    a_signed = 1'b1;
                end
                rv32i_types_pkg::alu_sub: begin
                    mul_op = 1'b1;    // MULHU
                end
                rv32i_types_pkg::alu_xor, rv32i_types_pkg::alu_or: begin
                    div_op   = 1'b1;  // DIV, REM
                    a_signed = 1'b1;
                    b_signed = 1'b1;
                end
                default: begin
                    div_op = 1'b1;    // DIVU, REMU
                end
            endcase
        end
    end

    assign base_op = !mul_op && !div_op;

    assign a_ext = {a_signed & a[muldiv_pkg::xlen-1], a};
    assign b_ext = {b_signed & b[muldiv_pkg::xlen-1], b};
    assign shamt = b[$clog2(muldiv_pkg::xlen)-1:0];

    always_comb begin
        case (aluop)
            rv32i_types_pkg::alu_add: base_res = a + b;
            rv32i_types_pkg::alu_sll: base_res = a << shamt;
            rv32i_types_pkg::alu_sra: base_res = muldiv_pkg::word_t'($signed(a) >>> shamt);
            rv32i_types_pkg::alu_sub: base_res = a - b;
            rv32i_types_pkg::alu_xor: base_res = a ^ b;
            rv32i_types_pkg::alu_srl: base_res = a >> shamt;
            rv32i_types_pkg::alu_or:  base_res = a | b;
            default:                  base_res = a & b;
        endcase
    end

    // MUL keeps the low word, the MULH forms the high word
    assign mul_res = (op_q == rv32i_types_pkg::alu_add) ?
                     ans[muldiv_pkg::xlen-1:0] : ans[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
    assign div_res = (op_q == rv32i_types_pkg::alu_xor || op_q == rv32i_types_pkg::alu_srl) ?
                     q : r;

    array_multiplier u_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a_ext),
        .b     (b_ext),
        .ans   (ans)
    );

    divider_control u_div_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start && div_op),
        .done  (div_done),
        .ctrl  (div_bus.ctrl)
    );

    divider u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .dividend  (a),
        .divisor   (b),
        .is_signed (a_signed),
        .dp        (div_bus.dp),
        .q         (q),
        .r         (r)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done        <= 1'b0;
            busy        <= 1'b0;
            mul_pending <= 1'b0;
        end else begin
            done        <= 1'b0;
            mul_pending <= start && mul_op;
            if (start && base_op) begin
                done <= 1'b1;  // Single-edge operation
            end else if (start) begin
                busy <= 1'b1;
            end
            if (mul_pending || div_done) begin
                done <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= aluop;
        end
        if (start && base_op) begin
            f <= base_res;
        end else if (mul_pending) begin
            f <= mul_res;
        end else if (div_done) begin
            f <= div_res;
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

    a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (start && mul_op) |-> ##(muldiv_pkg::mul_latency) done);

    a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (start && div_op) |-> ##(muldiv_pkg::div_latency) done);

endmodule : alu

/* hdl/divider_control.sv */
module divider_control (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    output logic     done,
    div_ctrl_if.ctrl ctrl
);

    muldiv_pkg::div_state_e state;
    muldiv_pkg::div_state_e state_next;
    muldiv_pkg::div_state_e phase;  // What the current cycle does
    muldiv_pkg::step_cnt_t  cnt;    // Steps completed

    // The cycle that carries start is the load phase, so the operands
    // are captured on the same edge that samples start
    always_comb begin
        phase = state;
        if (state == muldiv_pkg::idle && start) begin
            phase = muldiv_pkg::load;
        end
    end

    always_comb begin
        state_next = muldiv_pkg::idle;
        case (phase)
            muldiv_pkg::load: begin
                state_next = muldiv_pkg::step;
            end
            muldiv_pkg::step: begin
                if (cnt == muldiv_pkg::step_cnt_t'(muldiv_pkg::div_steps - 1)) begin
                    state_next = muldiv_pkg::fixup;  // Last iteration this cycle
                end else begin
                    state_next = muldiv_pkg::step;
                end
            end
            muldiv_pkg::fixup: begin
                state_next = muldiv_pkg::finish;
            end
            default: begin
                state_next = muldiv_pkg::idle;  // Idle without start, or finish
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= muldiv_pkg::idle;
            cnt   <= '0;
        end else begin
            state <= state_next;
            if (phase == muldiv_pkg::load) begin
                cnt <= '0;
            end else if (phase == muldiv_pkg::step) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign ctrl.load             = (phase == muldiv_pkg::load);
    assign ctrl.shift_en         = (phase == muldiv_pkg::step);
    assign ctrl.subtract_trigger = (phase == muldiv_pkg::step);
    assign ctrl.fixup            = (phase == muldiv_pkg::fixup);
    assign done                  = (phase == muldiv_pkg::finish);

    a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        cnt <= muldiv_pkg::step_cnt_t'(muldiv_pkg::div_steps));

    // Fixup only ever sees a full set of iterations
    a_steps_done: assert property (@(posedge clk) disable iff (!rst_n)
        (state == muldiv_pkg::fixup) |-> (cnt == muldiv_pkg::step_cnt_t'(muldiv_pkg::div_steps)));

endmodule : divider_control

/* hdl/divider.sv */
module divider (
    input  logic              clk,
    input  logic              rst_n,
    input  muldiv_pkg::word_t dividend,
    input  muldiv_pkg::word_t divisor,
    input  logic              is_signed,
    div_ctrl_if.dp            dp,
    output muldiv_pkg::word_t q,
    output muldiv_pkg::word_t r
);

    muldiv_pkg::word_t rem_q;    // Partial remainder
    muldiv_pkg::word_t quo_q;    // Dividend bits shift out, quotient bits shift in
    muldiv_pkg::word_t dvsr_q;   // Divisor magnitude
    muldiv_pkg::word_t quo_shift;
    muldiv_pkg::word_t most_neg;

    logic [muldiv_pkg::xlen:0]   rem_shift;  // Remainder after the shift, one bit wider
    logic [muldiv_pkg::xlen+1:0] trial;      // MSB set means the subtract borrowed

    logic q_neg;     // Quotient needs negation
    logic r_neg;     // Remainder follows dividend sign
    logic div_zero;
    logic ovf;       // Most negative divided by minus one

    assign most_neg = {1'b1, {(muldiv_pkg::xlen - 1){1'b0}}};

    // Bring the next dividend bit into the remainder
    assign rem_shift = dp.shift_en ? {rem_q, quo_q[muldiv_pkg::xlen-1]} : {1'b0, rem_q};
    assign quo_shift = dp.shift_en ? {quo_q[muldiv_pkg::xlen-2:0], 1'b0} : quo_q;
    assign trial     = {1'b0, rem_shift} - {2'b00, dvsr_q};

    // Sign and special-case flags, captured with the operands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_neg    <= 1'b0;
            r_neg    <= 1'b0;
            div_zero <= 1'b0;
            ovf      <= 1'b0;
        end else if (dp.load) begin
            q_neg    <= is_signed && (dividend[muldiv_pkg::xlen-1] ^ divisor[muldiv_pkg::xlen-1]);
            r_neg    <= is_signed && dividend[muldiv_pkg::xlen-1];
            div_zero <= (divisor == '0);
            ovf      <= is_signed && (dividend == most_neg) && (divisor == '1);
        end
    end

    always_ff @(posedge clk) begin
        if (dp.load) begin
            rem_q  <= '0;
            quo_q  <= (is_signed && dividend[muldiv_pkg::xlen-1]) ? -dividend : dividend;
            dvsr_q <= (is_signed && divisor[muldiv_pkg::xlen-1]) ? -divisor : divisor;
        end else if (dp.subtract_trigger && !trial[muldiv_pkg::xlen+1]) begin
            rem_q <= trial[muldiv_pkg::xlen-1:0];       // Trial fits, keep it
            quo_q <= {quo_shift[muldiv_pkg::xlen-1:1], 1'b1};
        end else if (dp.shift_en) begin
            rem_q <= rem_shift[muldiv_pkg::xlen-1:0];   // Restore
            quo_q <= quo_shift;
        end else if (dp.fixup) begin
            if (div_zero) begin
                // Remainder already holds the dividend magnitude here
                quo_q <= '1;
                rem_q <= r_neg ? -rem_q : rem_q;
            end else if (ovf) begin
                quo_q <= most_neg;
                rem_q <= '0;
            end else begin
                quo_q <= q_neg ? -quo_q : quo_q;
                rem_q <= r_neg ? -rem_q : rem_q;
            end
        end
    end

    assign q = quo_q;
    assign r = rem_q;

endmodule : divider

/* hdl/array_multiplier.sv */
module array_multiplier (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic signed [muldiv_pkg::xlen:0]  a,
    input  logic signed [muldiv_pkg::xlen:0]  b,
    output muldiv_pkg::product_t              ans
);

    muldiv_pkg::product_t a_ext;                        // Multiplicand at product width
    muldiv_pkg::product_t rows [muldiv_pkg::xlen+1];    // Partial-product rows
    muldiv_pkg::product_t sum;

    // Sign-extend the 33-bit multiplicand to 64 bits
    assign a_ext = {{(muldiv_pkg::xlen - 1){a[muldiv_pkg::xlen]}}, a};

    // One row per multiplier bit.
    // The top bit of b is its sign, so that row carries negative weight.
    always_comb begin
        for (int i = 0; i < muldiv_pkg::xlen; i++) begin
            rows[i] = b[i] ? (a_ext << i) : '0;
        end
        rows[muldiv_pkg::xlen] = b[muldiv_pkg::xlen] ?
                                 (~(a_ext << muldiv_pkg::xlen) + 1'b1) : '0;
    end

    // Accumulate rows, modulo 2**64 keeps the low product bits exact
    always_comb begin
        sum = '0;
        for (int i = 0; i <= muldiv_pkg::xlen; i++) begin
            sum = sum + rows[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ans <= '0;
        end else begin
            ans <= sum;  // Product register, loads every cycle
        end
    end

endmodule : array_multiplier

/* hdl/div_ctrl_if.sv */
interface div_ctrl_if;

    logic load;              // Capture magnitudes and sign flags
    logic shift_en;          // Shift next dividend bit into remainder
    logic subtract_trigger;  // Trial subtract, set quotient bit
    logic fixup;             // Sign correction and RISC-V special cases

    // Sequencer side
    modport ctrl (
        output load,
        output shift_en,
        output subtract_trigger,
        output fixup
    );

    // Datapath side
    modport dp (
        input load,
        input shift_en,
        input subtract_trigger,
        input fixup
    );

endinterface : div_ctrl_if

/* hdl/muldiv_pkg.sv */
package muldiv_pkg;

    localparam int xlen = 32;  // Word width

    localparam int div_steps = xlen;  // One shift-subtract per dividend bit

    // Edge counts from the edge that samples start to the edge that raises done
    localparam int mul_latency = 2;              // Product register, result register
    localparam int div_latency = div_steps + 3;  // Load, steps, fixup, result register

    typedef logic [xlen-1:0]   word_t;
    typedef logic [2*xlen-1:0] product_t;  // Full product

    // Step counter, wide enough to hold div_steps itself
    typedef logic [$clog2(div_steps):0] step_cnt_t;

    typedef enum logic [2:0] {
        idle,    // Waiting for a divide
        load,    // Operands captured
        step,    // Shift-subtract iterations
        fixup,   // Signs and special cases applied
        finish   // Result valid, done to alu
    } div_state_e;

endpackage : muldiv_pkg

/* hdl/rv32i_types_pkg.sv */
package rv32i_types_pkg;

    // funct7 field of an R-type instruction
    typedef logic [6:0] funct7_t;

    // Base ALU operation codes.
    // Under funct7_muldiv the same codes select the M extension operations.
    typedef enum logic [2:0] {
        alu_add = 3'b000,  // MUL under M
        alu_sll = 3'b001,  // MULH under M
        alu_sra = 3'b010,  // MULHSU under M
        alu_sub = 3'b011,  // MULHU under M
        alu_xor = 3'b100,  // DIV under M
        alu_srl = 3'b101,  // DIVU under M
        alu_or  = 3'b110,  // REM under M
        alu_and = 3'b111   // REMU under M
    } alu_ops;

    // funct7 value that selects the M extension
    localparam funct7_t funct7_muldiv = 7'b0000001;

endpackage : rv32i_types_pkg
